//--- design/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W = 11;  // 2 K bytes
    localparam int DATA_W = 8;

    // upper nibble of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // r/w flag, lsb of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    typedef enum logic [3:0] {
        MS_IDLE    = 4'd0,
        MS_START   = 4'd1,
        MS_CTRL_WR = 4'd2,
        MS_ADDR    = 4'd3,
        MS_DATA_WR = 4'd4,
        MS_RESTART = 4'd5,
        MS_CTRL_RD = 4'd6,
        MS_DATA_RD = 4'd7,
        MS_STOP    = 4'd8,
        MS_DONE    = 4'd9
    } main_state_t;

    // one op is one scl period, four quarters
    typedef enum logic [1:0] {
        OP_START = 2'd0,
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2,
        OP_READ  = 2'd3
    } bit_op_t;

endpackage

`default_nettype wire

//--- design/byte_shifter.sv
`default_nettype none

module byte_shifter (
    input  wire logic                           CLK,
    input  wire logic                           RESET,
    input  wire logic                           load,
    input  wire logic [eeprom_pkg::DATA_W-1:0]  load_byte,
    input  wire logic                           shift,
    input  wire logic                           shift_in,
    output logic                                ser_out,
    output logic [eeprom_pkg::DATA_W-1:0]       byte_out,
    output logic                                last_bit
);

    localparam int CNT_W = $clog2(eeprom_pkg::DATA_W);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(eeprom_pkg::DATA_W - 1);

    logic [eeprom_pkg::DATA_W-1:0] sreg;
    logic [CNT_W-1:0]              bit_cnt;

    // msb goes out first, received bits enter at bit 0
    always_ff @(posedge CLK) begin
        if (load) begin
            sreg <= load_byte;
        end else if (shift) begin
            sreg <= {sreg[eeprom_pkg::DATA_W-2:0], shift_in};
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            bit_cnt <= '0;
        end else if (load) begin
            bit_cnt <= '0;
        end else if (shift) begin
            bit_cnt <= bit_cnt + 1'b1;  // wraps after the eighth bit
        end
    end

    assign ser_out  = sreg[eeprom_pkg::DATA_W-1];
    assign byte_out = sreg;
    assign last_bit = (bit_cnt == CNT_LAST);

endmodule

`default_nettype wire

//--- design/i2c_bit_engine.sv
`default_nettype none

module i2c_bit_engine #(
    parameter int QUARTER_CYCLES = 2
) (
    input  wire logic                 CLK,
    input  wire logic                 RESET,
    input  wire logic                 op_valid,
    input  wire eeprom_pkg::bit_op_t  op,
    input  wire logic                 tx_bit,
    input  wire logic                 sda_in,
    output logic                      op_done,
    output logic                      rx_bit,
    output logic                      scl,
    output logic                      sda_drive_low
);

    localparam int QW = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;
    localparam logic [QW-1:0] Q_LAST = QW'(QUARTER_CYCLES - 1);

    logic                busy;
    logic [QW-1:0]       qcnt;
    logic [1:0]          phase;
    logic                active;
    logic                q_last;
    eeprom_pkg::bit_op_t op_q;
    logic                tx_q;
    eeprom_pkg::bit_op_t cur_op;
    logic                cur_tx;

    // the op_valid cycle already counts as quarter 0
    assign active  = busy | op_valid;
    assign q_last  = (qcnt == Q_LAST);
    assign cur_op  = busy ? op_q : op;
    assign cur_tx  = busy ? tx_q : tx_bit;
    assign op_done = busy & (phase == 2'd3) & q_last;

    always_ff @(posedge CLK) begin
        if (op_valid) begin
            op_q <= op;
            tx_q <= tx_bit;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy  <= 1'b0;
            qcnt  <= '0;
            phase <= 2'd0;
        end else if (active) begin
            if (q_last) begin
                qcnt  <= '0;
                phase <= phase + 2'd1;  // back to 0 after quarter 3
            end else begin
                qcnt <= qcnt + 1'b1;
            end
            busy <= ~op_done;
        end
    end

    // pins follow the quarter one cycle later and hold between ops
    always_ff @(posedge CLK) begin
        if (RESET) begin
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end else if (active) begin
            case (cur_op)
                eeprom_pkg::OP_START: begin
                    case (phase)
                        2'd0:    sda_drive_low <= 1'b0;  // scl left as is
                        2'd1:    scl <= 1'b1;
                        2'd2:    sda_drive_low <= 1'b1;  // falling sda, scl high
                        default: scl <= 1'b0;
                    endcase
                end
                eeprom_pkg::OP_STOP: begin
                    case (phase)
                        2'd0: begin
                            scl           <= 1'b0;
                            sda_drive_low <= 1'b1;
                        end
                        2'd1:    scl <= 1'b1;
                        2'd2:    sda_drive_low <= 1'b0;  // rising sda, bus idle
                        default: ;
                    endcase
                end
                default: begin
                    case (phase)
                        2'd0: begin
                            scl           <= 1'b0;
                            sda_drive_low <= (cur_op == eeprom_pkg::OP_WRITE) & ~cur_tx;
                        end
                        2'd1:    scl <= 1'b1;
                        2'd2:    scl <= 1'b1;
                        default: scl <= 1'b0;
                    endcase
                end
            endcase
        end
    end

    // middle of scl high
    always_ff @(posedge CLK) begin
        if (active && cur_op == eeprom_pkg::OP_READ && phase == 2'd2 && qcnt == '0) begin
            rx_bit <= sda_in;
        end
    end

endmodule

`default_nettype wire

//--- design/eeprom_ctrl.sv
`default_nettype none

module eeprom_ctrl (
    input  wire logic                           CLK,
    input  wire logic                           RESET,
    input  wire logic                           wr,
    input  wire logic                           rd,
    input  wire logic [eeprom_pkg::ADDR_W-1:0]  addr,
    input  wire logic [eeprom_pkg::DATA_W-1:0]  wdata,
    input  wire logic                           op_done,
    input  wire logic                           rx_bit,
    input  wire logic                           ser_out,
    input  wire logic                           last_bit,
    input  wire logic [eeprom_pkg::DATA_W-1:0]  byte_out,
    output logic                                ack,
    output logic                                nack_err,
    output logic [eeprom_pkg::DATA_W-1:0]       rdata,
    output logic                                op_valid,
    output eeprom_pkg::bit_op_t                 op,
    output logic                                tx_bit,
    output logic                                load,
    output logic [eeprom_pkg::DATA_W-1:0]       load_byte,
    output logic                                shift,
    output logic                                shift_in
);

    eeprom_pkg::main_state_t       state;
    logic                          is_read;
    logic                          ack_phase;  // ninth op of a byte
    logic                          ack_err;
    logic [eeprom_pkg::DATA_W-1:0] ctrl_wr_byte;
    logic [eeprom_pkg::DATA_W-1:0] ctrl_rd_byte;

    // device code, block select a10..a8, r/w
    assign ctrl_wr_byte = {eeprom_pkg::DEVICE_CODE,
                           addr[eeprom_pkg::ADDR_W-1:eeprom_pkg::DATA_W],
                           eeprom_pkg::RW_WRITE};
    assign ctrl_rd_byte = {eeprom_pkg::DEVICE_CODE,
                           addr[eeprom_pkg::ADDR_W-1:eeprom_pkg::DATA_W],
                           eeprom_pkg::RW_READ};

    assign tx_bit   = (state == eeprom_pkg::MS_DATA_RD) ? 1'b1 : ser_out;  // master nack
    assign shift_in = rx_bit;

    // shifter moves on the op_done edge so the next op sees the new msb
    always_comb begin
        load      = 1'b0;
        load_byte = ctrl_wr_byte;
        shift     = 1'b0;
        case (state)
            eeprom_pkg::MS_START: load = op_done;
            eeprom_pkg::MS_RESTART: begin
                load      = op_done;
                load_byte = ctrl_rd_byte;
            end
            eeprom_pkg::MS_CTRL_WR: begin
                load      = op_done & ack_phase;
                load_byte = addr[eeprom_pkg::DATA_W-1:0];
                shift     = op_done & ~ack_phase & ~last_bit;
            end
            eeprom_pkg::MS_ADDR: begin
                load      = op_done & ack_phase & ~is_read;
                load_byte = wdata;
                shift     = op_done & ~ack_phase & ~last_bit;
            end
            eeprom_pkg::MS_CTRL_RD: begin
                load      = op_done & ack_phase;  // clears the count for the read byte
                load_byte = '0;
                shift     = op_done & ~ack_phase & ~last_bit;
            end
            eeprom_pkg::MS_DATA_WR: shift = op_done & ~ack_phase & ~last_bit;
            eeprom_pkg::MS_DATA_RD: shift = op_done & ~ack_phase;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= eeprom_pkg::MS_IDLE;
            op_valid  <= 1'b0;
            op        <= eeprom_pkg::OP_STOP;
            is_read   <= 1'b0;
            ack_phase <= 1'b0;
            ack_err   <= 1'b0;
            ack       <= 1'b0;
            nack_err  <= 1'b0;
        end else begin
            op_valid <= 1'b0;
            ack      <= 1'b0;
            nack_err <= 1'b0;
            case (state)
                eeprom_pkg::MS_IDLE: begin
                    if (wr || rd) begin
                        is_read   <= ~wr;  // write wins
                        ack_err   <= 1'b0;
                        ack_phase <= 1'b0;
                        op_valid  <= 1'b1;
                        op        <= eeprom_pkg::OP_START;
                        state     <= eeprom_pkg::MS_START;
                    end
                end
                eeprom_pkg::MS_START: begin
                    if (op_done) begin
                        op_valid <= 1'b1;
                        op       <= eeprom_pkg::OP_WRITE;
                        state    <= eeprom_pkg::MS_CTRL_WR;
                    end
                end
                eeprom_pkg::MS_RESTART: begin
                    if (op_done) begin
                        op_valid <= 1'b1;
                        op       <= eeprom_pkg::OP_WRITE;
                        state    <= eeprom_pkg::MS_CTRL_RD;
                    end
                end
                eeprom_pkg::MS_CTRL_WR, eeprom_pkg::MS_ADDR,
                eeprom_pkg::MS_DATA_WR, eeprom_pkg::MS_CTRL_RD: begin
                    if (op_done) begin
                        op_valid <= 1'b1;
                        if (!ack_phase) begin
                            op        <= last_bit ? eeprom_pkg::OP_READ : eeprom_pkg::OP_WRITE;
                            ack_phase <= last_bit;
                        end else begin
                            ack_phase <= 1'b0;
                            ack_err   <= ack_err | rx_bit;  // slave ack is low
                            case (state)
                                eeprom_pkg::MS_CTRL_WR: begin
                                    op    <= eeprom_pkg::OP_WRITE;
                                    state <= eeprom_pkg::MS_ADDR;
                                end
                                eeprom_pkg::MS_ADDR: begin
                                    if (is_read) begin
                                        op    <= eeprom_pkg::OP_START;
                                        state <= eeprom_pkg::MS_RESTART;
                                    end else begin
                                        op    <= eeprom_pkg::OP_WRITE;
                                        state <= eeprom_pkg::MS_DATA_WR;
                                    end
                                end
                                eeprom_pkg::MS_CTRL_RD: begin
                                    op    <= eeprom_pkg::OP_READ;
                                    state <= eeprom_pkg::MS_DATA_RD;
                                end
                                default: begin
                                    op    <= eeprom_pkg::OP_STOP;
                                    state <= eeprom_pkg::MS_STOP;
                                end
                            endcase
                        end
                    end
                end
                eeprom_pkg::MS_DATA_RD: begin
                    if (op_done) begin
                        op_valid <= 1'b1;
                        if (!ack_phase) begin
                            op        <= last_bit ? eeprom_pkg::OP_WRITE : eeprom_pkg::OP_READ;
                            ack_phase <= last_bit;
                        end else begin
                            ack_phase <= 1'b0;
                            op        <= eeprom_pkg::OP_STOP;
                            state     <= eeprom_pkg::MS_STOP;
                        end
                    end
                end
                eeprom_pkg::MS_STOP: begin
                    if (op_done) begin
                        ack      <= 1'b1;
                        nack_err <= ack_err;
                        state    <= eeprom_pkg::MS_DONE;
                    end
                end
                eeprom_pkg::MS_DONE: state <= eeprom_pkg::MS_IDLE;
                default: state <= eeprom_pkg::MS_IDLE;
            endcase
        end
    end

    // byte_out holds through the stop op, rdata only moves with ack
    always_ff @(posedge CLK) begin
        if (state == eeprom_pkg::MS_STOP && op_done && is_read) begin
            rdata <= byte_out;
        end
    end

endmodule

`default_nettype wire

//--- design/eeprom_top.sv
`default_nettype none

module eeprom_top #(
    parameter int QUARTER_CYCLES = 2
) (
    input  wire logic                           CLK,
    input  wire logic                           RESET,
    input  wire logic                           wr,
    input  wire logic                           rd,
    input  wire logic [eeprom_pkg::ADDR_W-1:0]  addr,
    input  wire logic [eeprom_pkg::DATA_W-1:0]  wdata,
    input  wire logic                           sda_in,
    output logic                                ack,
    output logic                                nack_err,
    output logic [eeprom_pkg::DATA_W-1:0]       rdata,
    output logic                                scl,
    output logic                                sda_drive_low
);

    logic                          op_valid;
    eeprom_pkg::bit_op_t           op;
    logic                          tx_bit;
    logic                          op_done;
    logic                          rx_bit;
    logic                          load;
    logic [eeprom_pkg::DATA_W-1:0] load_byte;
    logic                          shift;
    logic                          shift_in;
    logic                          ser_out;
    logic [eeprom_pkg::DATA_W-1:0] byte_out;
    logic                          last_bit;

    eeprom_ctrl i_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .op_done   (op_done),
        .rx_bit    (rx_bit),
        .ser_out   (ser_out),
        .last_bit  (last_bit),
        .byte_out  (byte_out),
        .ack       (ack),
        .nack_err  (nack_err),
        .rdata     (rdata),
        .op_valid  (op_valid),
        .op        (op),
        .tx_bit    (tx_bit),
        .load      (load),
        .load_byte (load_byte),
        .shift     (shift),
        .shift_in  (shift_in)
    );

    // scl period is 4 * QUARTER_CYCLES clocks
    i2c_bit_engine #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    ) i_bit_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .op_valid      (op_valid),
        .op            (op),
        .tx_bit        (tx_bit),
        .sda_in        (sda_in),
        .op_done       (op_done),
        .rx_bit        (rx_bit),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

    byte_shifter i_shifter (
        .CLK       (CLK),
        .RESET     (RESET),
        .load      (load),
        .load_byte (load_byte),
        .shift     (shift),
        .shift_in  (shift_in),
        .ser_out   (ser_out),
        .byte_out  (byte_out),
        .last_bit  (last_bit)
    );

endmodule

`default_nettype wire

//--- dv/eeprom_model.sv
`default_nettype none

module eeprom_model (
    input  wire logic scl,
    input  wire logic sda,
    input  wire logic mute,
    output logic      pull_low
);

    localparam int M_IDLE  = 0;
    localparam int M_CTRL  = 1;
    localparam int M_ADDR  = 2;
    localparam int M_WDATA = 3;
    localparam int M_RDATA = 4;

    logic [7:0]  mem [0:2047];
    bit          written [0:2047];
    logic [10:0] ptr = '0;
    logic [7:0]  sr = '0;
    logic [7:0]  tx = '0;
    int          bit_cnt = 0;
    int          mode = M_IDLE;
    logic        do_ack = 1'b0;
    logic        drive_low = 1'b0;
    logic        prev_scl = 1'b1;
    logic        prev_sda = 1'b1;

    assign pull_low = drive_low;

    // low byte inverted, block number folded into the top bits
    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return ~a[7:0] ^ {a[10:8], 5'b00000};
    endfunction

    function automatic logic [7:0] read_byte(input logic [10:0] a);
        return written[a] ? mem[a] : fill_byte(a);
    endfunction

    always @(posedge scl or negedge scl or posedge sda or negedge sda) begin
        if (scl && prev_scl && sda != prev_sda) begin
            // sda moved while scl high, start or stop
            mode      = sda ? M_IDLE : M_CTRL;
            bit_cnt   = 0;
            do_ack    = 1'b0;
            drive_low = 1'b0;
        end else if (scl && !prev_scl && mode != M_IDLE) begin
            if (bit_cnt < 8) begin
                sr      = {sr[6:0], sda};
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8) begin
                    do_ack = 1'b0;
                    case (mode)
                        M_CTRL: begin
                            if (!mute && sr[7:4] == eeprom_pkg::DEVICE_CODE) begin
                                do_ack    = 1'b1;
                                ptr[10:8] = sr[3:1];  // block select
                                mode      = sr[0] ? M_RDATA : M_ADDR;
                                tx        = read_byte(ptr);
                            end else begin
                                mode = M_IDLE;
                            end
                        end
                        M_ADDR: begin
                            ptr[7:0] = sr;
                            mode     = M_WDATA;
                            do_ack   = 1'b1;
                        end
                        M_WDATA: begin
                            mem[ptr]     = sr;
                            written[ptr] = 1'b1;
                            ptr          = ptr + 11'd1;
                            do_ack       = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end else begin
                bit_cnt = 0;  // ninth clock
                if (mode == M_RDATA && !do_ack) begin
                    if (sda) begin
                        mode = M_IDLE;  // master nack ends the read
                    end else begin
                        ptr = ptr + 11'd1;
                        tx  = read_byte(ptr);
                    end
                end
            end
        end else if (!scl && prev_scl) begin
            if (mode == M_IDLE) begin
                drive_low = 1'b0;
            end else if (bit_cnt == 8) begin
                drive_low = do_ack;
            end else if (mode == M_RDATA) begin
                drive_low = ~tx[7 - bit_cnt];
            end else begin
                drive_low = 1'b0;
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

`default_nettype wire

//--- dv/eeprom_chk.sv
`default_nettype none

module eeprom_chk (
    input wire logic                CLK,
    input wire logic                RESET,
    input wire logic                ack,
    input wire logic                nack_err,
    input wire logic                scl,
    input wire logic                sda_drive_low,
    input wire eeprom_pkg::bit_op_t op
);

    ack_single: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else $error("ack high for more than one cycle");

    nack_single: assert property (@(posedge CLK) disable iff (RESET) nack_err |=> !nack_err)
        else $error("nack_err high for more than one cycle");

    nack_needs_ack: assert property (@(posedge CLK) disable iff (RESET) nack_err |-> ack)
        else $error("nack_err without ack");

    // data bits may only move while scl is low
    sda_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        (sda_drive_low != $past(sda_drive_low)) &&
        !(op inside {eeprom_pkg::OP_START, eeprom_pkg::OP_STOP}) |-> !scl && !$past(scl))
        else $error("master sda changed while scl high");

endmodule

bind eeprom_top eeprom_chk i_chk (
    .CLK           (CLK),
    .RESET         (RESET),
    .ack           (ack),
    .nack_err      (nack_err),
    .scl           (scl),
    .sda_drive_low (sda_drive_low),
    .op            (op)
);

`default_nettype wire

//--- dv/eeprom_tb.sv
`default_nettype none

module eeprom_tb;

    localparam int AW = eeprom_pkg::ADDR_W;
    localparam int DW = eeprom_pkg::DATA_W;
    localparam int ACK_TIMEOUT = 1000;
    localparam int WATCHDOG_CYCLES = 200000;

    logic          CLK = 1'b0;
    logic          RESET;
    logic          wr;
    logic          rd;
    logic [AW-1:0] addr;
    logic [DW-1:0] wdata;
    logic          mute;
    logic          ack;
    logic          nack_err;
    logic [DW-1:0] rdata;
    logic          scl;
    logic          sda_drive_low;
    logic          model_pull;
    logic          sda_line;

    logic [DW-1:0] shadow [0:(1 << AW)-1];
    bit            shadow_set [0:(1 << AW)-1];
    bit            exp_chk_data [$];
    logic [DW-1:0] exp_rdata [$];
    bit            exp_nack [$];
    integer        seed;
    int            errors = 0;
    int            errs_at_start = 0;
    int            tests_run = 0;
    int            tests_bad = 0;

    assign sda_line = ~(sda_drive_low | model_pull);  // pulled up, either side pulls low

    always #20 CLK = ~CLK;

    eeprom_top #(
        .QUARTER_CYCLES (2)
    ) i_dut (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wdata         (wdata),
        .sda_in        (sda_line),
        .ack           (ack),
        .nack_err      (nack_err),
        .rdata         (rdata),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

    eeprom_model i_eeprom (
        .scl      (scl),
        .sda      (sda_line),
        .mute     (mute),
        .pull_low (model_pull)
    );

    function automatic logic [DW-1:0] expected_read(input logic [AW-1:0] a);
        if (shadow_set[a]) begin
            return shadow[a];
        end
        return ~a[7:0] ^ {a[10:8], 5'b00000};  // model fill
    endfunction

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_and_finish();
        $display("summary: %0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // one host transaction, expectation queued for the compare process
    task automatic access(input bit do_wr, input bit do_rd, input logic [AW-1:0] a,
                          input logic [DW-1:0] d);
        int n;
        @(negedge CLK);
        wr    = do_wr;
        rd    = do_rd;
        addr  = a;
        wdata = d;
        exp_chk_data.push_back(!do_wr && !mute);
        exp_rdata.push_back(expected_read(a));
        exp_nack.push_back(mute);
        if (do_wr && !mute) begin
            shadow[a]     = d;
            shadow_set[a] = 1'b1;
        end
        n = 0;
        while (!ack && n < ACK_TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (!ack) begin
            $display("DUT gave no ack within %0d cycles at %0t", ACK_TIMEOUT, $time);
            errors++;
        end
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic end_test(input string name);
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (exp_nack.size() != 0 && n < ACK_TIMEOUT);
        if (exp_nack.size() != 0) begin
            $display("checks still pending at the end of test %s", name);
            errors++;
        end
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - errs_at_start);
        end
        errs_at_start = errors;
    endtask

    initial begin : compare_proc
        int n;
        forever begin
            @(negedge CLK);
            if (exp_nack.size() != 0) begin
                n = 0;
                while (!ack && n < ACK_TIMEOUT) begin
                    @(negedge CLK);
                    n++;
                end
                if (!ack) begin
                    $display("no ack seen for a pending check at %0t", $time);
                    errors++;
                end else begin
                    if (exp_chk_data[0]) begin
                        check("rdata", rdata, exp_rdata[0]);
                    end
                    check("nack_err", 8'(nack_err), 8'(exp_nack[0]));
                end
                exp_chk_data.delete(0);
                exp_rdata.delete(0);
                exp_nack.delete(0);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("simulation still running after %0d cycles", WATCHDOG_CYCLES);
        errors++;
        report_and_finish();
    end

    initial begin : stimulus
        int            r;
        int            idx;
        int            acks;
        logic [AW-1:0] a;
        logic [AW-1:0] addrs [$];
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        mute  = 1'b0;
        seed  = 28;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        check("scl", 8'(scl), 8'd1);
        check("sda_drive_low", 8'(sda_drive_low), 8'd0);
        acks = 0;
        repeat (20) begin
            @(negedge CLK);
            if (ack) begin
                acks++;
            end
        end
        check("ack", 8'(acks), 8'd0);
        end_test("idle after reset");

        access(1'b1, 1'b0, 11'h123, 8'h3e);
        access(1'b0, 1'b1, 11'h123, 8'h00);
        end_test("write then read");

        access(1'b0, 1'b1, 11'h5a3, 8'h00);
        end_test("unwritten read");

        // block bits cycle through all eight values
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            a = {3'(i % 8), r[7:0]};
            addrs.push_back(a);
            access(1'b1, 1'b0, a, r[15:8]);
        end
        while (addrs.size() != 0) begin
            r   = $random(seed);
            idx = int'(r[15:0]) % addrs.size();
            access(1'b0, 1'b1, addrs[idx], 8'h00);
            addrs.delete(idx);
        end
        end_test("random writes and reads");

        mute = 1'b1;
        access(1'b1, 1'b0, 11'h123, 8'ha7);
        access(1'b0, 1'b1, 11'h123, 8'h00);
        mute = 1'b0;
        access(1'b0, 1'b1, 11'h123, 8'h00);  // still the byte from test 2
        end_test("muted slave");

        access(1'b1, 1'b1, 11'h7f0, 8'hc3);
        access(1'b0, 1'b1, 11'h7f0, 8'h00);
        end_test("write priority");

        report_and_finish();
    end

endmodule

`default_nettype wire

//--- project.f
design/eeprom_pkg.sv
design/byte_shifter.sv
design/i2c_bit_engine.sv
design/eeprom_ctrl.sv
design/eeprom_top.sv
dv/eeprom_model.sv
dv/eeprom_chk.sv
dv/eeprom_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the eeprom testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module eeprom_tb -f project.f -o sim_eeprom &&
    ./obj_dir/sim_eeprom > sim.log 2>&1
grep -qs "tests failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -qs "all tests passed" sim.log || { echo "no pass result in sim.log"; exit 1; }
echo "simulation passed"
